/* viterbi_pkg.sv */
`default_nettype none

package viterbi_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // code definition
    ////////////////////////////////////////////////////////////////////////////

    localparam int CONSTRAINT_LEN = 5;
    // state keeps the last four input bits, newest in the msb
    localparam int STATE_W = CONSTRAINT_LEN - 1;
    localparam int NUM_STATES = 1 << STATE_W;

    // taps over {new input bit, state bits}, msb is the new input bit
    localparam logic [CONSTRAINT_LEN-1:0] GEN_POLY_0 = 5'o23;
    localparam logic [CONSTRAINT_LEN-1:0] GEN_POLY_1 = 5'o35;

    ////////////////////////////////////////////////////////////////////////////
    // decoder sizing
    ////////////////////////////////////////////////////////////////////////////

    // traceback window in symbols
    localparam int TB_DEPTH = 20;
    // survivor ring, next power of two above the window
    localparam int SURV_DEPTH = 32;
    localparam int SURV_AW = $clog2(SURV_DEPTH);

    localparam int METRIC_W = 7;

    // input buffer depth, also the credits upstream starts with
    localparam int IN_CREDITS = 4;
    // credits held towards the output sink after reset
    localparam int OUT_CREDITS = 4;

    ////////////////////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [METRIC_W-1:0] metric_t;

    // one received hard-decision symbol
    typedef struct packed {
        logic g0;
        logic g1;
    } code_sym_t;

    // bit s set when state s took its odd predecessor
    typedef logic [NUM_STATES-1:0] decision_t;

    typedef logic [SURV_AW-1:0] surv_addr_t;

endpackage

`default_nettype wire

/* symbol_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module symbol_fifo (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  viterbi_pkg::code_sym_t din,
    input  logic                  pop,
    output viterbi_pkg::code_sym_t head,
    output logic                  not_empty
);

    viterbi_pkg::code_sym_t mem [viterbi_pkg::IN_CREDITS];

    logic [$clog2(viterbi_pkg::IN_CREDITS)-1:0] wr_ptr;
    logic [$clog2(viterbi_pkg::IN_CREDITS)-1:0] rd_ptr;
    logic [$clog2(viterbi_pkg::IN_CREDITS+1)-1:0] count;

    // pointers and occupancy, upstream credits keep count below overflow
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

`default_nettype wire

/* acs_array.sv */
`timescale 1ns/1ns
`default_nettype none

module acs_array (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   step,
    input  viterbi_pkg::code_sym_t sym,
    output viterbi_pkg::decision_t decision,
    output viterbi_pkg::metric_t   metrics [viterbi_pkg::NUM_STATES]
);

    viterbi_pkg::metric_t   sum_even   [viterbi_pkg::NUM_STATES];
    viterbi_pkg::metric_t   sum_odd    [viterbi_pkg::NUM_STATES];
    viterbi_pkg::metric_t   nxt_metric [viterbi_pkg::NUM_STATES];
    viterbi_pkg::decision_t nxt_decision;
    logic [viterbi_pkg::NUM_STATES-1:0] top_bits;
    logic                               norm;

    // hamming distance between the received pair and the pair coded on a branch
    function automatic logic [1:0] branch_dist(
        input logic [viterbi_pkg::CONSTRAINT_LEN-1:0] path,
        input viterbi_pkg::code_sym_t                 rx
    );
        logic exp0;
        logic exp1;
        exp0 = ^(path & viterbi_pkg::GEN_POLY_0);
        exp1 = ^(path & viterbi_pkg::GEN_POLY_1);
        return {1'b0, exp0 ^ rx.g0} + {1'b0, exp1 ^ rx.g1};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // add-compare-select, one butterfly half per state
    ////////////////////////////////////////////////////////////////////////////

    for (genvar s = 0; s < viterbi_pkg::NUM_STATES; s++) begin : g_acs
        // encoder register on the branch into s is {s, low bit of predecessor}
        assign sum_even[s] = metrics[(2 * s) % viterbi_pkg::NUM_STATES]
            + viterbi_pkg::metric_t'(branch_dist({viterbi_pkg::STATE_W'(s), 1'b0}, sym));
        assign sum_odd[s] = metrics[(2 * s + 1) % viterbi_pkg::NUM_STATES]
            + viterbi_pkg::metric_t'(branch_dist({viterbi_pkg::STATE_W'(s), 1'b1}, sym));

        // strict compare, an equal sum stays with the even predecessor
        assign nxt_decision[s] = (sum_odd[s] < sum_even[s]);
        assign nxt_metric[s]   = nxt_decision[s] ? sum_odd[s] : sum_even[s];
        assign top_bits[s]     = nxt_metric[s][viterbi_pkg::METRIC_W-1];
    end

    // every survivor is in the upper half, shift them all down together
    assign norm = &top_bits;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // encoder starts in state 0, the others begin far behind
            for (int s = 0; s < viterbi_pkg::NUM_STATES; s++) begin
                metrics[s] <= (s == 0) ? '0
                    : viterbi_pkg::metric_t'(1 << (viterbi_pkg::METRIC_W - 1));
            end
        end else if (step) begin
            for (int s = 0; s < viterbi_pkg::NUM_STATES; s++) begin
                metrics[s] <= {nxt_metric[s][viterbi_pkg::METRIC_W-1] & ~norm,
                               nxt_metric[s][viterbi_pkg::METRIC_W-2:0]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            decision <= nxt_decision;
        end
    end

endmodule

`default_nettype wire

/* survivor_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module survivor_ram (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    write,
    input  viterbi_pkg::decision_t  wdata,
    output viterbi_pkg::surv_addr_t waddr,
    input  viterbi_pkg::surv_addr_t raddr,
    output viterbi_pkg::decision_t  rdata
);

    viterbi_pkg::decision_t mem [viterbi_pkg::SURV_DEPTH];

    // ring pointer, wraps on its own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            waddr <= '0;
        end else if (write) begin
            waddr <= waddr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
    end

    // asynchronous read so traceback advances one row per cycle
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* traceback_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module traceback_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  viterbi_pkg::metric_t    metrics [viterbi_pkg::NUM_STATES],
    input  viterbi_pkg::surv_addr_t newest,
    output viterbi_pkg::surv_addr_t raddr,
    input  viterbi_pkg::decision_t  rdata,
    output logic                    done,
    output logic                    dec_bit
);

    logic [viterbi_pkg::STATE_W-1:0] best_state;
    logic [viterbi_pkg::STATE_W-1:0] cur_state;
    logic [viterbi_pkg::STATE_W-1:0] prev_state;
    viterbi_pkg::metric_t            best_metric;
    viterbi_pkg::surv_addr_t         ptr;
    logic [$clog2(viterbi_pkg::TB_DEPTH)-1:0] walk_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // best state search
    ////////////////////////////////////////////////////////////////////////////

    // linear scan, strict compare keeps the lowest index on a tie
    always_comb begin
        best_state  = '0;
        best_metric = metrics[0];
        for (int s = 1; s < viterbi_pkg::NUM_STATES; s++) begin
            if (metrics[s] < best_metric) begin
                best_metric = metrics[s];
                best_state  = viterbi_pkg::STATE_W'(s);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // backward walk
    ////////////////////////////////////////////////////////////////////////////

    // predecessor is the state shifted up with the decision bit shifted in
    assign prev_state = {cur_state[viterbi_pkg::STATE_W-2:0], rdata[cur_state]};
    assign raddr      = ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            walk_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                walk_cnt <= $bits(walk_cnt)'(viterbi_pkg::TB_DEPTH - 1);
            end else if (walk_cnt != '0) begin
                walk_cnt <= walk_cnt - 1'b1;
                // last row read, decoded bit is ready next cycle
                done     <= (walk_cnt == 1);
            end
        end
    end

    // first read is the row written while start is high
    always_ff @(posedge clk) begin
        if (start) begin
            cur_state <= best_state;
            ptr       <= newest;
        end else if (walk_cnt != '0) begin
            cur_state <= prev_state;
            ptr       <= ptr - 1'b1;
        end
    end

    // msb of a state is the input bit that entered it
    assign dec_bit = cur_state[viterbi_pkg::STATE_W-1];

endmodule

`default_nettype wire

/* viterbi_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module viterbi_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sym_valid,
    input  viterbi_pkg::code_sym_t sym,
    output logic                   sym_credit,
    output logic                   out_valid,
    output logic                   out_bit,
    input  logic                   out_credit
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ACS,
        SEQ_TRACE
    } seq_state_t;

    seq_state_t                       seq_state;
    viterbi_pkg::code_sym_t           head;
    logic                             not_empty;
    logic                             accept;
    logic                             window_full;
    logic                             surv_write;
    logic                             tb_start;
    logic                             tb_done;
    logic                             tb_bit;
    viterbi_pkg::decision_t           decision;
    viterbi_pkg::decision_t           surv_rdata;
    viterbi_pkg::metric_t             metrics [viterbi_pkg::NUM_STATES];
    viterbi_pkg::surv_addr_t          surv_waddr;
    viterbi_pkg::surv_addr_t          surv_raddr;
    logic [$clog2(viterbi_pkg::TB_DEPTH)-1:0]      sym_count;
    logic [$clog2(viterbi_pkg::OUT_CREDITS+1)-1:0] out_credits;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////

    // saturates once enough steps are stored for a full traceback
    assign window_full = (sym_count == $bits(sym_count)'(viterbi_pkg::TB_DEPTH - 1));

    // a symbol that will produce an output needs a credit in hand
    assign accept = (seq_state == SEQ_IDLE) && not_empty
                    && (!window_full || (out_credits != '0));

    assign sym_credit = accept;
    assign surv_write = (seq_state == SEQ_ACS);
    assign tb_start   = (seq_state == SEQ_ACS) && window_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq_state <= SEQ_IDLE;
            sym_count <= '0;
        end else begin
            case (seq_state)
                SEQ_IDLE: begin
                    if (accept) begin
                        seq_state <= SEQ_ACS;
                    end
                end
                SEQ_ACS: begin
                    if (window_full) begin
                        seq_state <= SEQ_TRACE;
                    end else begin
                        seq_state <= SEQ_IDLE;
                        sym_count <= sym_count + 1'b1;
                    end
                end
                SEQ_TRACE: begin
                    if (tb_done) begin
                        seq_state <= SEQ_IDLE;
                    end
                end
                default: seq_state <= SEQ_IDLE;
            endcase
        end
    end

    // output credits, one back per sink pulse and one spent per bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_credits <= $bits(out_credits)'(viterbi_pkg::OUT_CREDITS);
        end else begin
            case ({out_credit, out_valid})
                2'b10:   out_credits <= out_credits + 1'b1;
                2'b01:   out_credits <= out_credits - 1'b1;
                default: out_credits <= out_credits;
            endcase
        end
    end

    assign out_valid = tb_done;
    assign out_bit   = tb_bit;

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    symbol_fifo symbol_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (sym_valid),
        .din       (sym),
        .pop       (accept),
        .head      (head),
        .not_empty (not_empty)
    );

    acs_array acs_array_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .step     (accept),
        .sym      (head),
        .decision (decision),
        .metrics  (metrics)
    );

    survivor_ram survivor_ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .write (surv_write),
        .wdata (decision),
        .waddr (surv_waddr),
        .raddr (surv_raddr),
        .rdata (surv_rdata)
    );

    traceback_unit traceback_unit_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (tb_start),
        .metrics (metrics),
        .newest  (surv_waddr),
        .raddr   (surv_raddr),
        .rdata   (surv_rdata),
        .done    (tb_done),
        .dec_bit (tb_bit)
    );

endmodule

`default_nettype wire

/* tb_conv_model.svh */
`ifndef TB_CONV_MODEL_SVH
`define TB_CONV_MODEL_SVH

// reference encoder step, shift register is {new bit, state}
// state keeps the last four inputs with the newest in the msb
task automatic encode_bit(
    input  logic                   in_bit,
    inout  logic [3:0]             enc_state,
    output viterbi_pkg::code_sym_t code
);
    logic [4:0] shift_reg;
    shift_reg = {in_bit, enc_state};
    code.g0   = ^(shift_reg & 5'o23);
    code.g1   = ^(shift_reg & 5'o35);
    enc_state = shift_reg[4:1];
endtask

// channel error on one of the two code bits
function automatic viterbi_pkg::code_sym_t flip_code_bit(
    input viterbi_pkg::code_sym_t code,
    input logic                   second
);
    viterbi_pkg::code_sym_t hit;
    hit = code;
    if (second) begin
        hit.g1 = ~hit.g1;
    end else begin
        hit.g0 = ~hit.g0;
    end
    return hit;
endfunction

`endif

/* tb_viterbi.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_viterbi;

    `include "tb_conv_model.svh"

    localparam int TAIL = viterbi_pkg::TB_DEPTH - 1;
    localparam int TOTAL_SYMS = (40 + TAIL) + (60 + TAIL) + (281 + TAIL) + (60 + TAIL);
    // time budget per symbol is twice a full traceback pass
    localparam int WATCHDOG_NS = TOTAL_SYMS * (viterbi_pkg::TB_DEPTH + 4) * 10 * 2;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   sym_valid;
    viterbi_pkg::code_sym_t sym;
    logic                   sym_credit;
    logic                   out_valid;
    logic                   out_bit;
    logic                   out_credit;

    int   seed = 32'h719c;
    int   in_credits = viterbi_pkg::IN_CREDITS;
    int   dec_credits = viterbi_pkg::OUT_CREDITS;
    int   sent_count = 0;
    int   credit_pulses = 0;
    int   out_seen = 0;
    int   error_count = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    logic throttle = 1'b0;

    logic                   exp_q [$];
    viterbi_pkg::code_sym_t tx_q [$];

    viterbi_decoder viterbi_decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sym_valid  (sym_valid),
        .sym        (sym),
        .sym_credit (sym_credit),
        .out_valid  (out_valid),
        .out_bit    (out_bit),
        .out_credit (out_credit)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // monitors and protocol checks
    ////////////////////////////////////////////////////////////////////////////

    // credit bookkeeping and output compare on the rising edge
    always @(posedge clk) begin
        logic exp_bit;
        if (!rst_n) begin
            in_credits    = viterbi_pkg::IN_CREDITS;
            dec_credits   = viterbi_pkg::OUT_CREDITS;
            credit_pulses = 0;
            out_seen      = 0;
        end else begin
            if (sym_credit) begin
                in_credits++;
                credit_pulses++;
            end
            if (out_credit) begin
                dec_credits++;
            end
            if (out_valid) begin
                dec_credits--;
                out_seen++;
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("decoder produced a bit at %0t with none left to expect", $time);
                end else begin
                    exp_bit = exp_q.pop_front();
                    assert (out_bit === exp_bit) else begin
                        error_count++;
                        $display("MISMATCH at %0t: output %0d is %0b, expected %0b",
                                 $time, out_seen, out_bit, exp_bit);
                    end
                end
            end
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        (sent_count == 0) |-> (!out_valid && !sym_credit))
        else begin
            error_count++;
            $display("decoder was active at %0t before any symbol was sent", $time);
        end

    a_out_credit_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (dec_credits > 0))
        else begin
            error_count++;
            $display("out_valid pulsed at %0t while the decoder held no output credit", $time);
        end

    // more credits than buffer slots means a credit came back for no symbol
    a_in_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
        (in_credits >= 0) && (in_credits <= viterbi_pkg::IN_CREDITS))
        else begin
            error_count++;
            $display("upstream credit count went negative or above the buffer depth at %0t",
                     $time);
        end

    // sink hands back owed credits and only rarely when throttled
    always @(negedge clk) begin
        if (rst_n && (dec_credits < viterbi_pkg::OUT_CREDITS)
            && (!throttle || (($random(seed) & 32'h1f) == 0))) begin
            out_credit = 1'b1;
        end else begin
            out_credit = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        @(negedge clk);
        rst_n      = 1'b0;
        sym_valid  = 1'b0;
        sent_count = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // one symbol per falling edge whenever a credit is held
    task automatic send_symbols();
        int idx;
        idx = 0;
        while (idx < tx_q.size()) begin
            @(negedge clk);
            if (in_credits > 0) begin
                sym_valid  = 1'b1;
                sym        = tx_q[idx];
                in_credits = in_credits - 1;
                sent_count++;
                idx++;
            end else begin
                sym_valid = 1'b0;
            end
        end
        @(negedge clk);
        sym_valid = 1'b0;
    endtask

    task automatic run_test(input string name, input int msg_len, input int err_gap,
                            input logic slow_sink);
        viterbi_pkg::code_sym_t code;
        logic [3:0]             enc_state;
        logic                   msg_bit;
        logic [31:0]            rnd;
        int                     total;
        int                     errs_before;
        errs_before = error_count;
        total       = msg_len + TAIL;
        enc_state   = '0;
        exp_q.delete();
        tx_q.delete();
        // zero tail after the message brings the encoder back to state 0
        for (int k = 0; k < total; k++) begin
            msg_bit = 1'b0;
            if (k < msg_len) begin
                rnd     = $random(seed);
                msg_bit = rnd[0];
                exp_q.push_back(msg_bit);
            end
            encode_bit(msg_bit, enc_state, code);
            if ((err_gap > 0) && ((k % err_gap) == 5)) begin
                code = flip_code_bit(code, ((k / err_gap) % 2) == 1);
            end
            tx_q.push_back(code);
        end
        throttle = slow_sink;
        apply_reset();
        repeat (5) @(negedge clk);
        send_symbols();
        while (out_seen < msg_len) begin
            @(posedge clk);
        end
        // room for any extra bit to show up
        repeat (2 * (viterbi_pkg::TB_DEPTH + 4)) @(posedge clk);
        assert ((out_seen == msg_len) && (exp_q.size() == 0)) else begin
            error_count++;
            $display("MISMATCH at %0t: %0d bits out, expected %0d", $time, out_seen, msg_len);
        end
        assert (credit_pulses == sent_count) else begin
            error_count++;
            $display("MISMATCH at %0t: %0d input credits returned for %0d symbols",
                     $time, credit_pulses, sent_count);
        end
        throttle = 1'b0;
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %s: %0d symbols, %0d bits, ok", name, total, msg_len);
        end else begin
            tests_failed++;
            $display("test %s: %0d symbols, %0d errors", name, total,
                     error_count - errs_before);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        sym_valid  = 1'b0;
        sym        = '0;
        out_credit = 1'b0;
        run_test("clean_message", 40, 0, 1'b0);
        run_test("single_bit_errors", 60, 12, 1'b0);
        run_test("long_stream", 300 - TAIL, 0, 1'b0);
        run_test("output_back_pressure", 60, 0, 1'b1);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the decoder delivered every bit");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
viterbi_pkg.sv
symbol_fifo.sv
acs_array.sv
survivor_ram.sv
traceback_unit.sv
viterbi_decoder.sv
tb_viterbi.sv

/* run_sim.sh */
#!/bin/sh
# compile the decoder and its testbench with verilator, then run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_viterbi \
    -f build.f -o tb_viterbi \
    && ./obj_dir/tb_viterbi > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "compile or run error"; exit 1; }

cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && exit 1 || exit 0
